// ==== include/dac_macros.svh ====
////////////////////////////////////////
// widths and defaults for the AD5601 DAC controller
// DAC_CLK_DIV must be at least 1
////////////////////////////////////////
`ifndef DAC_MACROS_SVH
`define DAC_MACROS_SVH

// register port and frame widths
`define DAC_DATA_W          16
`define DAC_ADDR_W          15

// direct gain field inside the DAC word
`define DAC_GAIN_W          8
`define DAC_GAIN_LSB        6

// register defaults after interconnect reset
`define DAC_MODULE_VERSION  1
`define DAC_DEFAULT_WORD    100

// system cycles per half serial clock
`define DAC_CLK_DIV         2
// 1 sends the current word when the peripheral reset ends
`define DAC_SEND_ON_RESET   1

`endif

// ==== src/dac_pkg.sv ====
////////////////////////////////////////
// shared types of the DAC controller
// widths come from dac_macros.svh
////////////////////////////////////////
`include "dac_macros.svh"

package dac_pkg;

    ////////////////////////////////////////
    // register map
    ////////////////////////////////////////
    typedef enum logic [`DAC_ADDR_W-1:0] {
        addr_version  = 0,
        addr_dac_word = 1,
        addr_en_mmi   = 2,
        reg_count     = 3
    } dac_reg_addr_e;

    ////////////////////////////////////////
    // register port
    ////////////////////////////////////////
    // one-cycle strobes, never both high together
    typedef struct packed {
        logic                   wr_stb;
        logic                   rd_stb;
        logic [`DAC_ADDR_W-1:0] addr;
        logic [`DAC_DATA_W-1:0] wdata;
    } reg_req_t;

    // rd_valid comes one cycle after rd_stb
    typedef struct packed {
        logic                   rd_valid;
        logic [`DAC_DATA_W-1:0] rdata;
    } reg_rsp_t;

    // accepted change of the DAC word
    typedef struct packed {
        logic                   stb;
        logic [`DAC_DATA_W-1:0] word;
        logic                   direct;
    } dac_update_t;

    // serial pins toward the DAC
    typedef struct packed {
        logic sclk;
        logic sync_n;
        logic sdin;
    } spi_pins_t;

endpackage

// ==== src/dac_reg_bank.sv ====
////////////////////////////////////////
// register writes only act with en_mmi_ctrl high
// direct strobes only act with en_mmi_ctrl low
////////////////////////////////////////
`include "dac_macros.svh"

module dac_reg_bank (
    input  logic                   clk,
    input  logic                   interconnect_sreset,
    input  dac_pkg::reg_req_t      reg_req,
    input  logic                   en_mmi_ctrl,
    input  logic [`DAC_GAIN_W-1:0] dac_gain_in,
    input  logic                   dac_gain_stb,
    output dac_pkg::reg_rsp_t      reg_rsp,
    output dac_pkg::dac_update_t   dac_update,
    output logic [`DAC_DATA_W-1:0] dac_word
);
    import dac_pkg::*;

    logic [`DAC_DATA_W-1:0] dac_word_q;
    logic                   en_mmi_q;
    logic                   rd_valid_q;
    logic [`DAC_DATA_W-1:0] rdata_q;
    logic [`DAC_DATA_W-1:0] rd_mux;
    logic                   upd_stb_q;
    logic                   upd_direct_q;
    logic                   mmi_wr_ok;
    logic                   direct_ok;

    ////////////////////////////////////////
    // write source selection
    ////////////////////////////////////////
    assign mmi_wr_ok = reg_req.wr_stb && en_mmi_ctrl &&
                       (reg_req.addr == addr_dac_word);
    assign direct_ok = dac_gain_stb && !en_mmi_ctrl;

    always_ff @(posedge clk) begin
        if (interconnect_sreset) begin
            dac_word_q   <= `DAC_DEFAULT_WORD;
            en_mmi_q     <= 1'b0;
            rd_valid_q   <= 1'b0;
            upd_stb_q    <= 1'b0;
            upd_direct_q <= 1'b0;
        end else begin
            en_mmi_q   <= en_mmi_ctrl;
            rd_valid_q <= reg_req.rd_stb;
            // update pulse lines up with the new register value
            upd_stb_q  <= mmi_wr_ok | direct_ok;
            if (mmi_wr_ok) begin
                dac_word_q   <= reg_req.wdata;
                upd_direct_q <= 1'b0;
            end else if (direct_ok) begin
                dac_word_q[`DAC_GAIN_LSB +: `DAC_GAIN_W] <= dac_gain_in;
                upd_direct_q <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // read decode
    ////////////////////////////////////////
    always_comb begin
        rd_mux = '0;
        case (reg_req.addr)
            addr_version:  rd_mux = `DAC_DATA_W'(`DAC_MODULE_VERSION);
            addr_dac_word: rd_mux = dac_word_q;
            addr_en_mmi:   rd_mux = {{(`DAC_DATA_W-1){1'b0}}, en_mmi_q};
            // unmapped addresses read as zero
            default:       rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reg_req.rd_stb) begin
            rdata_q <= rd_mux;
        end
    end

    assign reg_rsp.rd_valid = rd_valid_q;
    assign reg_rsp.rdata    = rdata_q;

    // word field already holds the new value when stb is high
    assign dac_update.stb    = upd_stb_q;
    assign dac_update.word   = dac_word_q;
    assign dac_update.direct = upd_direct_q;

    assign dac_word = dac_word_q;

endmodule

// ==== src/dac_frame_seq.sv ====
////////////////////////////////////////
// one frame shifting, one pending, newest pending wins
// dropped middle values never pulse dac_gain_updated_stb
////////////////////////////////////////
`include "dac_macros.svh"

module dac_frame_seq (
    input  logic                   clk,
    input  logic                   interconnect_sreset,
    input  logic                   peripheral_sreset,
    input  dac_pkg::dac_update_t   dac_update,
    input  logic [`DAC_DATA_W-1:0] dac_word,
    input  logic                   busy,
    input  logic                   done,
    output logic                   start,
    output logic [`DAC_DATA_W-1:0] frame_word,
    output logic                   dac_gain_updated_stb
);
    import dac_pkg::*;

    logic                   rst_any;
    logic                   rst_q;
    logic                   reset_end;
    dac_update_t            pending_q;
    logic                   start_q;
    logic [`DAC_DATA_W-1:0] frame_word_q;
    logic                   frame_direct_q;
    logic                   gain_upd_q;
    logic                   idle;
    logic                   launch;
    logic [`DAC_DATA_W-1:0] next_word;
    logic                   next_direct;

    assign rst_any = interconnect_sreset | peripheral_sreset;

    // falling edge of either reset asks for one send
    always_ff @(posedge clk) begin
        rst_q <= rst_any;
    end

    assign reset_end = rst_q && !rst_any && (`DAC_SEND_ON_RESET != 0);

    ////////////////////////////////////////
    // launch decision
    ////////////////////////////////////////
    // start counts as in flight until busy takes over
    assign idle   = !start_q && !busy;
    assign launch = idle && (dac_update.stb || pending_q.stb || reset_end);

    always_comb begin
        if (dac_update.stb) begin
            next_word   = dac_update.word;
            next_direct = dac_update.direct;
        end else if (pending_q.stb) begin
            next_word   = pending_q.word;
            next_direct = pending_q.direct;
        end else begin
            next_word   = dac_word;
            next_direct = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_any) begin
            start_q        <= 1'b0;
            pending_q      <= '0;
            frame_direct_q <= 1'b0;
            gain_upd_q     <= 1'b0;
        end else begin
            start_q    <= launch;
            gain_upd_q <= done && frame_direct_q;
            if (launch) begin
                frame_direct_q <= next_direct;
                pending_q.stb  <= 1'b0;
            end else if (dac_update.stb) begin
                // frame busy, park the newest change
                pending_q <= dac_update;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            frame_word_q <= next_word;
        end
    end

    assign start                = start_q;
    assign frame_word           = frame_word_q;
    assign dac_gain_updated_stb = gain_upd_q;

endmodule

// ==== src/dac_spi_shift.sv ====
////////////////////////////////////////
// 16 bits MSB first, sclk idles low, DAC samples on falling sclk
// start while busy is ignored
////////////////////////////////////////
`include "dac_macros.svh"

module dac_spi_shift (
    input  logic                   clk,
    input  logic                   interconnect_sreset,
    input  logic                   peripheral_sreset,
    input  logic                   start,
    input  logic [`DAC_DATA_W-1:0] frame_word,
    output dac_pkg::spi_pins_t     spi,
    output logic                   busy,
    output logic                   done
);
    import dac_pkg::*;

    localparam int DIV_W = (`DAC_CLK_DIV > 1) ? $clog2(`DAC_CLK_DIV) : 1;
    localparam int BIT_W = $clog2(`DAC_DATA_W);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`DAC_CLK_DIV - 1);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`DAC_DATA_W - 1);
    localparam spi_pins_t SPI_IDLE = '{sclk: 1'b0, sync_n: 1'b1, sdin: 1'b0};

    logic                   rst_any;
    logic                   busy_q;
    logic                   done_q;
    logic                   sclk_q;
    logic                   sync_n_q;
    logic [DIV_W-1:0]       div_cnt;
    logic [BIT_W-1:0]       bit_cnt;
    logic [`DAC_DATA_W-1:0] shreg;

    assign rst_any = interconnect_sreset | peripheral_sreset;

    ////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////
    // each bit is sclk high for one half, then low for one half
    always_ff @(posedge clk) begin
        if (rst_any) begin
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            sclk_q   <= SPI_IDLE.sclk;
            sync_n_q <= SPI_IDLE.sync_n;
            div_cnt  <= '0;
            bit_cnt  <= '0;
        end else begin
            done_q <= 1'b0;
            if (!busy_q) begin
                if (start) begin
                    busy_q   <= 1'b1;
                    sync_n_q <= 1'b0;
                    sclk_q   <= 1'b1;
                    div_cnt  <= '0;
                    bit_cnt  <= '0;
                end
            end else if (div_cnt != DIV_LAST) begin
                div_cnt <= div_cnt + 1'b1;
            end else begin
                div_cnt <= '0;
                if (sclk_q) begin
                    // falling edge, data already stable
                    sclk_q <= 1'b0;
                end else if (bit_cnt == BIT_LAST) begin
                    busy_q   <= 1'b0;
                    sync_n_q <= 1'b1;
                    done_q   <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                    sclk_q  <= 1'b1;
                end
            end
        end
    end

    // shift on the rising half so sdin changes away from the sampling edge
    always_ff @(posedge clk) begin
        if (!busy_q && start) begin
            shreg <= frame_word;
        end else if (busy_q && div_cnt == DIV_LAST && !sclk_q && bit_cnt != BIT_LAST) begin
            shreg <= {shreg[`DAC_DATA_W-2:0], 1'b0};
        end
    end

    assign spi.sclk   = sclk_q;
    assign spi.sync_n = sync_n_q;
    assign spi.sdin   = !sync_n_q && shreg[`DAC_DATA_W-1];
    assign busy       = busy_q;
    assign done       = done_q;

endmodule

// ==== src/dac_ctrl_top.sv ====
////////////////////////////////////////
// register port reads answer in exactly one cycle
// peripheral_sreset leaves the registers untouched
////////////////////////////////////////
`include "dac_macros.svh"

module dac_ctrl_top (
    input  logic                   clk,
    input  logic                   interconnect_sreset,
    input  logic                   peripheral_sreset,
    input  logic                   en_mmi_ctrl,
    input  dac_pkg::reg_req_t      reg_req,
    input  logic [`DAC_GAIN_W-1:0] dac_gain_in,
    input  logic                   dac_gain_stb,
    output dac_pkg::reg_rsp_t      reg_rsp,
    output logic                   dac_gain_updated_stb,
    output dac_pkg::spi_pins_t     spi
);
    import dac_pkg::*;

    dac_update_t            dac_update;
    logic [`DAC_DATA_W-1:0] dac_word;
    logic                   start;
    logic [`DAC_DATA_W-1:0] frame_word;
    logic                   busy;
    logic                   done;

    // register access and write source selection
    dac_reg_bank i_dac_reg_bank (
        .clk                 (clk),
        .interconnect_sreset (interconnect_sreset),
        .reg_req             (reg_req),
        .en_mmi_ctrl         (en_mmi_ctrl),
        .dac_gain_in         (dac_gain_in),
        .dac_gain_stb        (dac_gain_stb),
        .reg_rsp             (reg_rsp),
        .dac_update          (dac_update),
        .dac_word            (dac_word)
    );

    // pending slot and send after reset
    dac_frame_seq i_dac_frame_seq (
        .clk                  (clk),
        .interconnect_sreset  (interconnect_sreset),
        .peripheral_sreset    (peripheral_sreset),
        .dac_update           (dac_update),
        .dac_word             (dac_word),
        .busy                 (busy),
        .done                 (done),
        .start                (start),
        .frame_word           (frame_word),
        .dac_gain_updated_stb (dac_gain_updated_stb)
    );

    // serial frame out
    dac_spi_shift i_dac_spi_shift (
        .clk                 (clk),
        .interconnect_sreset (interconnect_sreset),
        .peripheral_sreset   (peripheral_sreset),
        .start               (start),
        .frame_word          (frame_word),
        .spi                 (spi),
        .busy                (busy),
        .done                (done)
    );

endmodule

// ==== bench/tb_dac_ctrl.sv ====
////////////////////////////////////////
// directed tests of the DAC controller, frames captured from the serial pins
// a fixed seed keeps the random data repeatable
////////////////////////////////////////
`include "dac_macros.svh"

module tb_dac_ctrl;
    timeunit 1ns;
    timeprecision 100ps;

    import dac_pkg::*;

    // one frame plus start and done overhead
    localparam int FRAME_CYCLES   = `DAC_DATA_W * 2 * `DAC_CLK_DIV + 6;
    localparam int MAX_FRAMES     = 40;
    localparam int TIMEOUT_CYCLES = 2 * MAX_FRAMES * FRAME_CYCLES + 400;
    localparam int FRAME_WAIT     = 3 * FRAME_CYCLES;

    logic                   clk;
    logic                   interconnect_sreset;
    logic                   peripheral_sreset;
    logic                   en_mmi_ctrl;
    reg_req_t               reg_req;
    logic [`DAC_GAIN_W-1:0] dac_gain_in;
    logic                   dac_gain_stb;
    reg_rsp_t               reg_rsp;
    logic                   dac_gain_updated_stb;
    spi_pins_t              spi;

    logic [`DAC_DATA_W-1:0] frame_q[$];
    logic [`DAC_DATA_W-1:0] cap_shift;
    int                     cap_bits;
    int                     cut_frames;
    int                     gain_pulses;
    int                     exp_pulses;
    int                     cycle_count;
    logic                   prev_sclk;
    logic                   prev_sync_n;
    logic [`DAC_DATA_W-1:0] cur_word;

    dac_ctrl_top i_dac_ctrl_top (
        .clk                  (clk),
        .interconnect_sreset  (interconnect_sreset),
        .peripheral_sreset    (peripheral_sreset),
        .en_mmi_ctrl          (en_mmi_ctrl),
        .reg_req              (reg_req),
        .dac_gain_in          (dac_gain_in),
        .dac_gain_stb         (dac_gain_stb),
        .reg_rsp              (reg_rsp),
        .dac_gain_updated_stb (dac_gain_updated_stb),
        .spi                  (spi)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////
    // frame capture on the serial pins
    ////////////////////////////////////////
    // the DAC samples sdin on falling sclk
    // a frame counts only with all 16 bits
    always @(negedge clk) begin
        if (!spi.sync_n) begin
            if (prev_sclk && !spi.sclk) begin
                cap_shift = {cap_shift[`DAC_DATA_W-2:0], spi.sdin};
                cap_bits++;
            end
        end else begin
            if (!prev_sync_n) begin
                if (cap_bits == `DAC_DATA_W) begin
                    frame_q.push_back(cap_shift);
                end else begin
                    cut_frames++;
                end
            end
            cap_bits = 0;
        end
        prev_sclk   = spi.sclk;
        prev_sync_n = spi.sync_n;
        if (dac_gain_updated_stb) begin
            gain_pulses++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    ////////////////////////////////////////
    // failure reporting and compare tasks
    ////////////////////////////////////////
    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("ERR %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: rd_valid is %0b, expected %0b", what, got, exp));
        end
    endtask

    task automatic check_rdata(input logic [`DAC_DATA_W-1:0] got,
                               input logic [`DAC_DATA_W-1:0] exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: read 0x%04h, expected 0x%04h", what, got, exp));
        end
    endtask

    task automatic check_updated(input int exp_count);
        if (gain_pulses != exp_count) begin
            report_mismatch($sformatf("dac_gain_updated_stb pulsed %0d times, expected %0d",
                                      gain_pulses, exp_count));
        end
    endtask

    // waits for the next frame, then for the updated pulse that may follow it
    task automatic check_frame(input logic [`DAC_DATA_W-1:0] exp_word, input logic exp_direct);
        logic [`DAC_DATA_W-1:0] got;
        int                     waited;
        waited = 0;
        while (frame_q.size() == 0 && waited < FRAME_WAIT) begin
            next_cycle();
            waited++;
        end
        if (frame_q.size() == 0) begin
            report_failure($sformatf("no serial frame arrived, expected word 0x%04h", exp_word));
        end
        repeat (3) next_cycle();
        got = frame_q.pop_front();
        if (got !== exp_word) begin
            report_mismatch($sformatf("frame carried 0x%04h, expected 0x%04h", got, exp_word));
        end
        if (exp_direct) begin
            exp_pulses++;
        end
        check_updated(exp_pulses);
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) next_cycle();
        if (frame_q.size() != 0) begin
            report_failure("a serial frame was sent although no change was accepted");
        end
    endtask

    ////////////////////////////////////////
    // bus drivers
    ////////////////////////////////////////
    task automatic write_reg(input logic [`DAC_ADDR_W-1:0] addr,
                             input logic [`DAC_DATA_W-1:0] data);
        reg_req.wr_stb = 1'b1;
        reg_req.addr   = addr;
        reg_req.wdata  = data;
        next_cycle();
        reg_req.wr_stb = 1'b0;
    endtask

    // rd_valid must be high on the first edge after the strobe and low on the next
    task automatic read_reg(input logic [`DAC_ADDR_W-1:0] addr,
                            output logic [`DAC_DATA_W-1:0] data);
        reg_req.rd_stb = 1'b1;
        reg_req.addr   = addr;
        next_cycle();
        reg_req.rd_stb = 1'b0;
        check_valid(reg_rsp.rd_valid, 1'b1, "one cycle after rd_stb");
        data = reg_rsp.rdata;
        next_cycle();
        check_valid(reg_rsp.rd_valid, 1'b0, "two cycles after rd_stb");
    endtask

    task automatic expect_reg(input logic [`DAC_ADDR_W-1:0] addr,
                              input logic [`DAC_DATA_W-1:0] exp);
        logic [`DAC_DATA_W-1:0] data;
        read_reg(addr, data);
        check_rdata(data, exp, $sformatf("register %0d", addr));
    endtask

    task automatic strobe_gain(input logic [`DAC_GAIN_W-1:0] gain);
        dac_gain_in  = gain;
        dac_gain_stb = 1'b1;
        next_cycle();
        dac_gain_stb = 1'b0;
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic test_reset_readback();
        expect_reg(addr_version, `DAC_MODULE_VERSION);
        expect_reg(addr_dac_word, `DAC_DEFAULT_WORD);
        expect_reg(addr_en_mmi, 16'(en_mmi_ctrl));
        for (int a = 3; a <= 6; a++) begin
            expect_reg(`DAC_ADDR_W'(a), '0);
        end
        check_frame(`DAC_DEFAULT_WORD, 1'b0);
    endtask

    task automatic test_reg_writes();
        cur_word = `DAC_DATA_W'($urandom);
        write_reg(addr_dac_word, cur_word);
        expect_reg(addr_dac_word, cur_word);
        check_frame(cur_word, 1'b0);
        // read-only and unmapped addresses
        write_reg(addr_version, `DAC_DATA_W'($urandom));
        write_reg(addr_en_mmi, 16'h0000);
        write_reg(`DAC_ADDR_W'(5), `DAC_DATA_W'($urandom));
        expect_reg(addr_version, `DAC_MODULE_VERSION);
        expect_reg(addr_en_mmi, 16'h0001);
        expect_reg(`DAC_ADDR_W'(5), '0);
        expect_reg(addr_dac_word, cur_word);
        expect_quiet(FRAME_CYCLES);
        check_updated(exp_pulses);
    endtask

    task automatic test_direct_writes();
        logic [`DAC_GAIN_W-1:0] gain;
        en_mmi_ctrl = 1'b0;
        next_cycle();
        expect_reg(addr_en_mmi, 16'h0000);
        for (int i = 0; i < 4; i++) begin
            gain = `DAC_GAIN_W'($urandom);
            strobe_gain(gain);
            cur_word[`DAC_GAIN_LSB +: `DAC_GAIN_W] = gain;
            check_frame(cur_word, 1'b1);
        end
        // the register port has no write access in this mode
        write_reg(addr_dac_word, ~cur_word);
        expect_reg(addr_dac_word, cur_word);
        expect_quiet(FRAME_CYCLES);
    endtask

    task automatic test_ignored_gain();
        en_mmi_ctrl = 1'b1;
        next_cycle();
        for (int i = 0; i < 3; i++) begin
            strobe_gain(`DAC_GAIN_W'($urandom));
        end
        expect_reg(addr_dac_word, cur_word);
        expect_quiet(FRAME_CYCLES);
        check_updated(exp_pulses);
    endtask

    task automatic test_writes_in_frame();
        logic [`DAC_DATA_W-1:0] first_word;
        logic [`DAC_DATA_W-1:0] mid_word;
        logic [`DAC_DATA_W-1:0] last_word;
        first_word = `DAC_DATA_W'($urandom);
        mid_word   = `DAC_DATA_W'($urandom);
        last_word  = `DAC_DATA_W'($urandom);
        write_reg(addr_dac_word, first_word);
        write_reg(addr_dac_word, mid_word);
        write_reg(addr_dac_word, last_word);
        cur_word = last_word;
        check_frame(first_word, 1'b0);
        check_frame(last_word, 1'b0);
        expect_reg(addr_dac_word, last_word);
        expect_quiet(FRAME_CYCLES);
    endtask

    task automatic test_peripheral_reset();
        int waited;
        cur_word = `DAC_DATA_W'($urandom);
        write_reg(addr_dac_word, cur_word);
        waited = 0;
        while (spi.sync_n && waited < 20) begin
            next_cycle();
            waited++;
        end
        if (spi.sync_n) begin
            report_failure("the frame did not start before the peripheral reset");
        end
        // reset lands near the middle of the frame
        repeat (FRAME_CYCLES / 2) next_cycle();
        peripheral_sreset = 1'b1;
        repeat (3) next_cycle();
        peripheral_sreset = 1'b0;
        expect_reg(addr_version, `DAC_MODULE_VERSION);
        expect_reg(addr_dac_word, cur_word);
        check_frame(cur_word, 1'b0);
        if (cut_frames != 1) begin
            report_failure("the peripheral reset did not cut the running frame short");
        end
        expect_quiet(FRAME_CYCLES);
    endtask

    initial begin
        clk                 = 1'b0;
        interconnect_sreset = 1'b1;
        peripheral_sreset   = 1'b1;
        en_mmi_ctrl         = 1'b1;
        reg_req             = '0;
        dac_gain_in         = '0;
        dac_gain_stb        = 1'b0;
        cap_shift           = '0;
        cap_bits            = 0;
        cut_frames          = 0;
        gain_pulses         = 0;
        exp_pulses          = 0;
        cycle_count         = 0;
        prev_sclk           = 1'b0;
        prev_sync_n         = 1'b1;
        cur_word            = `DAC_DEFAULT_WORD;
        void'($urandom(77307));

        repeat (8) @(posedge clk);
        #1;
        interconnect_sreset = 1'b0;
        peripheral_sreset   = 1'b0;

        test_reset_readback();
        test_reg_writes();
        test_direct_writes();
        test_ignored_gain();
        test_writes_in_frame();
        test_peripheral_reset();

        $display("No errors");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
src/dac_pkg.sv
src/dac_reg_bank.sv
src/dac_frame_seq.sv
src/dac_spi_shift.sv
src/dac_ctrl_top.sv
bench/tb_dac_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the DAC controller testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_dac_ctrl \
    -f src.f \
    -o sim_tb_dac_ctrl

# keep the simulator output even when the run stops on an error
sim_out=$(./obj_dir/sim_tb_dac_ctrl 2>&1 || true)
echo "$sim_out"

if echo "$sim_out" | grep -qx "No errors"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
